//--- Makefile
SIM = obj_dir/Vfu_main_tb

all: run

$(SIM): vlog.f include/fu_cfg.svh $(wildcard hdl/*.sv) $(wildcard verif/*.sv)
	verilator --binary --timing --assert --top-module fu_main_tb -f vlog.f

run: $(SIM)
	$(SIM) | tee sim.log
	grep -q "All tests passed" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: all run clean

//--- hdl/fu_alu.sv
`include "fu_cfg.svh"

module fu_alu (
	input  logic                  clk,
	input  logic                  arst_n_i,
	fu_issue_if.sink              issue,
	input  logic                  recovery_i,
	input  logic                  pred_correct_i,
	input  logic [`BR_MASK_W-1:0] tag_fix_i,
	fu_result_if.source           result
);
	import fu_pkg::*;

	localparam int SHAMT_W = $clog2(`FU_XLEN);

	logic [`FU_XLEN-1:0] alu_val;
	logic                in_kill;
	logic                done_r;
	fu_result_t          res_r;

	always_comb begin
		case (issue.func)
			alu_add:   alu_val = issue.opa + issue.opb;
			alu_sub:   alu_val = issue.opa - issue.opb;
			alu_and:   alu_val = issue.opa & issue.opb;
			alu_or:    alu_val = issue.opa | issue.opb;
			alu_xor:   alu_val = issue.opa ^ issue.opb;
			alu_sll:   alu_val = issue.opa << issue.opb[SHAMT_W-1:0];
			alu_srl:   alu_val = issue.opa >> issue.opb[SHAMT_W-1:0];
			alu_cmplt: alu_val = {{(`FU_XLEN-1){1'b0}}, ($signed(issue.opa) < $signed(issue.opb))};
			default:   alu_val = '0;
		endcase
	end

	// squashed at issue by an overlapping recovery
	assign in_kill = recovery_i && |(issue.tag.br_mask & tag_fix_i);

	always_ff @(posedge clk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			done_r <= 1'b0;
		end else begin
			done_r <= issue.alu_start && !in_kill;
		end
	end

	always_ff @(posedge clk) begin
		res_r.value       <= alu_val;
		res_r.tag.dest    <= issue.tag.dest;
		res_r.tag.rob_idx <= issue.tag.rob_idx;
		// resolved branch drops out of the mask
		res_r.tag.br_mask <= pred_correct_i ? (issue.tag.br_mask & ~tag_fix_i) : issue.tag.br_mask;
	end

	assign result.done = done_r;
	assign result.res  = res_r;

	// fixed latency, the arbiter always gives the ALU the bus
	assert property (@(posedge clk) disable iff (!arst_n_i) !result.hold);

endmodule

//--- hdl/fu_br.sv
`include "fu_cfg.svh"

module fu_br (
	input  logic                  clk,
	input  logic                  arst_n_i,
	fu_issue_if.sink              issue,
	input  logic                  recovery_i,
	output logic                  br_done_o,
	output logic                  br_taken_o,
	output logic [`FU_XLEN-1:0]   br_target_o,
	output logic [`ROB_IDX_W-1:0] br_rob_idx_o
);
	import fu_pkg::*;

	logic                  taken;
	logic                  done_r;
	logic                  taken_r;
	logic [`FU_XLEN-1:0]   target_r;
	logic [`ROB_IDX_W-1:0] rob_idx_r;

	// operand a compared against zero
	always_comb begin
		case (issue.cond)
			br_eq:     taken = (issue.opa == '0);
			br_ne:     taken = (issue.opa != '0);
			br_lt:     taken = issue.opa[`FU_XLEN-1];
			br_ge:     taken = !issue.opa[`FU_XLEN-1];
			br_always: taken = 1'b1;
			default:   taken = 1'b0;
		endcase
	end

	always_ff @(posedge clk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			done_r <= 1'b0;
		end else begin
			done_r <= issue.br_start;
		end
	end

	always_ff @(posedge clk) begin
		taken_r   <= taken;
		target_r  <= issue.npc + issue.disp;
		rob_idx_r <= issue.tag.rob_idx;
	end

	// a recovery in the output cycle drops the result
	assign br_done_o    = done_r && !recovery_i;
	assign br_taken_o   = taken_r;
	assign br_target_o  = target_r;
	assign br_rob_idx_o = rob_idx_r;

endmodule

//--- hdl/fu_cdb_arb.sv
`include "fu_cfg.svh"

module fu_cdb_arb (
	fu_result_if.sink             alu_res,
	fu_result_if.sink             mult_res,
	input  logic                  br_done_i,
	input  logic [`ROB_IDX_W-1:0] br_rob_idx_i,
	input  logic                  recovery_i,
	output logic                  cdb_vld_o,
	output logic [`PRF_IDX_W-1:0] cdb_tag_o,
	output logic [`FU_XLEN-1:0]   cdb_value_o,
	output logic                  rob_done_o,
	output logic [`ROB_IDX_W-1:0] rob_idx_o
);
	import fu_pkg::*;

	logic       alu_win;
	logic       mult_win;
	logic       win_vld;
	fu_result_t win;

	// multiplier waits on ALU, branch completion or recovery
	assign mult_res.hold = mult_res.done && (alu_res.done || br_done_i || recovery_i);

	// branch takes the ROB port, ALU completion would have to wait
	assign alu_res.hold = alu_res.done && br_done_i;

	assign alu_win  = alu_res.done && !recovery_i;
	assign mult_win = mult_res.done && !mult_res.hold;
	assign win_vld  = alu_win || mult_win;
	assign win      = alu_win ? alu_res.res : mult_res.res;

	// zero register completes without a write
	assign cdb_vld_o   = win_vld && (win.tag.dest != `PRF_IDX_W'(`ZERO_REG));
	assign cdb_tag_o   = win.tag.dest;
	assign cdb_value_o = win.value;

	// branch first, then the bus winner
	assign rob_done_o = br_done_i || win_vld;
	assign rob_idx_o  = br_done_i ? br_rob_idx_i : win.tag.rob_idx;

endmodule

//--- hdl/fu_if.sv
`include "fu_cfg.svh"

// decoded operation from the issue stage to the units
interface fu_issue_if;
	import fu_pkg::*;

	// one-hot unit strobes
	logic                alu_start;
	logic                br_start;
	logic                mult_start;
	logic [`FU_XLEN-1:0] opa;
	logic [`FU_XLEN-1:0] opb;
	alu_func_e           func;
	br_cond_e            cond;
	logic [`FU_XLEN-1:0] npc;
	logic [`FU_XLEN-1:0] disp;
	fu_tag_t             tag;

	modport source (
		output alu_start, br_start, mult_start, opa, opb, func, cond, npc, disp, tag
	);

	modport sink (
		input alu_start, br_start, mult_start, opa, opb, func, cond, npc, disp, tag
	);

endinterface

// completed result, hold flows back from the consumer
interface fu_result_if;
	import fu_pkg::*;

	logic       done;
	fu_result_t res;
	logic       hold;

	modport source (output done, res, input hold);
	modport sink (input done, res, output hold);

endinterface

//--- hdl/fu_issue_decode.sv
`include "fu_cfg.svh"

module fu_issue_decode (
	input  logic                clk,
	input  logic                arst_n_i,
	input  logic                iss_vld_i,
	input  fu_pkg::fu_sel_e     sel_i,
	input  fu_pkg::alu_func_e   func_i,
	input  fu_pkg::br_cond_e    cond_i,
	input  logic [`FU_XLEN-1:0] opa_i,
	input  logic [`FU_XLEN-1:0] opb_i,
	input  logic [`FU_XLEN-1:0] npc_i,
	input  logic [`FU_XLEN-1:0] disp_i,
	input  fu_pkg::fu_tag_t     tag_i,
	input  logic                mult_hold_i,
	fu_issue_if.source          issue,
	output logic                mult_rdy_o
);
	import fu_pkg::*;

	// unit strobes
	assign issue.alu_start  = iss_vld_i && (sel_i == sel_alu);
	assign issue.br_start   = iss_vld_i && (sel_i == sel_cond_branch || sel_i == sel_uncond_branch);
	assign issue.mult_start = iss_vld_i && (sel_i == sel_mult);

	// unconditional branches always resolve taken
	assign issue.cond = (sel_i == sel_uncond_branch) ? br_always : cond_i;

	assign issue.func = func_i;
	assign issue.opa  = opa_i;
	assign issue.opb  = opb_i;
	assign issue.npc  = npc_i;
	assign issue.disp = disp_i;
	assign issue.tag  = tag_i;

	// stage 0 full and frozen cannot take a new multiply
	assign mult_rdy_o = !mult_hold_i;

	assert property (@(posedge clk) disable iff (!arst_n_i)
		$onehot0({issue.alu_start, issue.br_start, issue.mult_start}));

	// reservation station must respect multiplier readiness
	assert property (@(posedge clk) disable iff (!arst_n_i)
		issue.mult_start |-> mult_rdy_o);

endmodule

//--- hdl/fu_main.sv
`include "fu_cfg.svh"

module fu_main (
	input  logic                  clk,
	input  logic                  arst_n_i,
	input  logic                  iss_vld_i,
	input  fu_pkg::fu_sel_e       sel_i,
	input  fu_pkg::alu_func_e     func_i,
	input  fu_pkg::br_cond_e      cond_i,
	input  logic [`FU_XLEN-1:0]   opa_i,
	input  logic [`FU_XLEN-1:0]   opb_i,
	input  logic [`FU_XLEN-1:0]   npc_i,
	input  logic [`FU_XLEN-1:0]   disp_i,
	input  fu_pkg::fu_tag_t       tag_i,
	input  logic                  recovery_i,
	input  logic                  pred_correct_i,
	input  logic [`BR_MASK_W-1:0] tag_fix_i,
	output logic                  preg_wr_en_o,
	output logic [`PRF_IDX_W-1:0] preg_wr_idx_o,
	output logic [`FU_XLEN-1:0]   preg_wr_value_o,
	output logic                  cdb_vld_o,
	output logic                  rob_done_o,
	output logic [`ROB_IDX_W-1:0] rob_idx_o,
	output logic                  br_done_o,
	output logic                  br_taken_o,
	output logic [`FU_XLEN-1:0]   br_target_o,
	output logic                  mult_rdy_o
);

	logic                  cdb_vld;
	logic [`ROB_IDX_W-1:0] br_rob_idx;
	logic [`FU_XLEN-1:0]   mcand [`MULT_STAGES+1];
	logic [`FU_XLEN-1:0]   mplier [`MULT_STAGES+1];

	fu_issue_if  issue ();
	fu_result_if alu_res ();
	// link i feeds stage i, the last link feeds the arbiter
	fu_result_if mult_link [`MULT_STAGES+1] ();

	assign mult_link[0].done = issue.mult_start;
	assign mult_link[0].res  = '{tag: issue.tag, value: '0};
	assign mcand[0]          = issue.opa;
	assign mplier[0]         = issue.opb;

	assign preg_wr_en_o = cdb_vld;
	assign cdb_vld_o    = cdb_vld;

	fu_issue_decode fu_issue_decode_inst (
		.clk         (clk),
		.arst_n_i    (arst_n_i),
		.iss_vld_i   (iss_vld_i),
		.sel_i       (sel_i),
		.func_i      (func_i),
		.cond_i      (cond_i),
		.opa_i       (opa_i),
		.opb_i       (opb_i),
		.npc_i       (npc_i),
		.disp_i      (disp_i),
		.tag_i       (tag_i),
		.mult_hold_i (mult_link[0].hold),
		.issue       (issue),
		.mult_rdy_o  (mult_rdy_o)
	);

	fu_alu fu_alu_inst (
		.clk            (clk),
		.arst_n_i       (arst_n_i),
		.issue          (issue),
		.recovery_i     (recovery_i),
		.pred_correct_i (pred_correct_i),
		.tag_fix_i      (tag_fix_i),
		.result         (alu_res)
	);

	fu_br fu_br_inst (
		.clk          (clk),
		.arst_n_i     (arst_n_i),
		.issue        (issue),
		.recovery_i   (recovery_i),
		.br_done_o    (br_done_o),
		.br_taken_o   (br_taken_o),
		.br_target_o  (br_target_o),
		.br_rob_idx_o (br_rob_idx)
	);

	for (genvar i = 0; i < `MULT_STAGES; i++) begin : g_mult
		fu_mult_stage fu_mult_stage_inst (
			.clk            (clk),
			.arst_n_i       (arst_n_i),
			.upstream       (mult_link[i]),
			.issue_start_i  ((i == 0) ? issue.mult_start : 1'b0),
			.multiplicand_i (mcand[i]),
			.multiplier_i   (mplier[i]),
			.recovery_i     (recovery_i),
			.pred_correct_i (pred_correct_i),
			.tag_fix_i      (tag_fix_i),
			.downstream     (mult_link[i+1]),
			.multiplicand_o (mcand[i+1]),
			.multiplier_o   (mplier[i+1])
		);
	end

	fu_cdb_arb fu_cdb_arb_inst (
		.alu_res      (alu_res),
		.mult_res     (mult_link[`MULT_STAGES]),
		.br_done_i    (br_done_o),
		.br_rob_idx_i (br_rob_idx),
		.recovery_i   (recovery_i),
		.cdb_vld_o    (cdb_vld),
		.cdb_tag_o    (preg_wr_idx_o),
		.cdb_value_o  (preg_wr_value_o),
		.rob_done_o   (rob_done_o),
		.rob_idx_o    (rob_idx_o)
	);

endmodule

//--- hdl/fu_mult_stage.sv
`include "fu_cfg.svh"

module fu_mult_stage (
	input  logic                  clk,
	input  logic                  arst_n_i,
	fu_result_if.sink             upstream,
	input  logic                  issue_start_i,
	input  logic [`FU_XLEN-1:0]   multiplicand_i,
	input  logic [`FU_XLEN-1:0]   multiplier_i,
	input  logic                  recovery_i,
	input  logic                  pred_correct_i,
	input  logic [`BR_MASK_W-1:0] tag_fix_i,
	fu_result_if.source           downstream,
	output logic [`FU_XLEN-1:0]   multiplicand_o,
	output logic [`FU_XLEN-1:0]   multiplier_o
);
	import fu_pkg::*;

	// multiplier bits consumed per stage
	localparam int SLICE_W = `FU_XLEN / `MULT_STAGES;

	logic                  done_r;
	fu_tag_t               tag_r;
	logic [`FU_XLEN-1:0]   acc_r;
	logic [`FU_XLEN-1:0]   mcand_r;
	logic [`FU_XLEN-1:0]   mplier_r;
	logic                  stall;
	logic                  in_kill;
	logic                  held_kill;
	logic [`FU_XLEN-1:0]   acc_in;
	logic [`FU_XLEN-1:0]   slice_pp;
	logic [`BR_MASK_W-1:0] in_mask;

	assign stall         = done_r && downstream.hold;
	assign upstream.hold = stall;

	// a fresh multiply starts from an empty accumulator
	assign acc_in   = issue_start_i ? '0 : upstream.res.value;
	assign slice_pp = multiplicand_i *
		{{(`FU_XLEN-SLICE_W){1'b0}}, multiplier_i[SLICE_W-1:0]};

	assign in_kill   = recovery_i && |(upstream.res.tag.br_mask & tag_fix_i);
	assign held_kill = recovery_i && |(tag_r.br_mask & tag_fix_i);
	assign in_mask   = pred_correct_i ? (upstream.res.tag.br_mask & ~tag_fix_i)
		: upstream.res.tag.br_mask;

	always_ff @(posedge clk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			done_r <= 1'b0;
		end else if (stall) begin
			done_r <= !held_kill;
		end else begin
			done_r <= upstream.done && !in_kill;
		end
	end

	always_ff @(posedge clk) begin
		if (stall) begin
			// frozen entry still sees resolved branches
			if (pred_correct_i) begin
				tag_r.br_mask <= tag_r.br_mask & ~tag_fix_i;
			end
		end else begin
			tag_r.dest    <= upstream.res.tag.dest;
			tag_r.rob_idx <= upstream.res.tag.rob_idx;
			tag_r.br_mask <= in_mask;
			acc_r         <= acc_in + slice_pp;
			mcand_r       <= multiplicand_i << SLICE_W;
			mplier_r      <= multiplier_i >> SLICE_W;
		end
	end

	assign downstream.done = done_r;
	assign downstream.res  = '{tag: tag_r, value: acc_r};
	assign multiplicand_o  = mcand_r;
	assign multiplier_o    = mplier_r;

	// an entry offered while this stage is held must wait upstream
	assert property (@(posedge clk) disable iff (!arst_n_i)
		stall && upstream.done && !in_kill |=> upstream.done);

endmodule

//--- hdl/fu_pkg.sv
`include "fu_cfg.svh"

package fu_pkg;

	// target execution unit
	typedef enum logic [`FU_ENUM_W-1:0] {
		sel_none,
		sel_alu,
		sel_cond_branch,
		sel_uncond_branch,
		sel_mult
	} fu_sel_e;

	typedef enum logic [`FU_ENUM_W-1:0] {
		alu_add,
		alu_sub,
		alu_and,
		alu_or,
		alu_xor,
		alu_sll,
		alu_srl,
		alu_cmplt
	} alu_func_e;

	// condition tested on operand a against zero
	typedef enum logic [`FU_ENUM_W-1:0] {
		br_eq,
		br_ne,
		br_lt,
		br_ge,
		br_always
	} br_cond_e;

	typedef struct packed {
		logic [`PRF_IDX_W-1:0] dest;
		logic [`ROB_IDX_W-1:0] rob_idx;
		logic [`BR_MASK_W-1:0] br_mask;
	} fu_tag_t;

	typedef struct packed {
		fu_tag_t               tag;
		logic [`FU_XLEN-1:0]   value;
	} fu_result_t;

endpackage

//--- include/fu_cfg.svh
`ifndef FU_CFG_SVH
`define FU_CFG_SVH

// datapath width of the cluster
`define FU_XLEN 64

// reorder buffer index
`define ROB_IDX_W 5

// physical register tag
`define PRF_IDX_W 6

// one bit per unresolved branch
`define BR_MASK_W 4

// multiplier pipeline depth, must divide FU_XLEN (2, 4 or 8)
`define MULT_STAGES 4

// hard-wired zero register, never written
`define ZERO_REG 31

// width of the decoded select, function and condition codes
`define FU_ENUM_W 3

`endif

//--- verif/fu_main_tb.sv
`include "fu_cfg.svh"

module fu_main_tb;
	import fu_pkg::*;

	localparam int CLK_PERIOD = 8;
	localparam int M = `MULT_STAGES;
	localparam int SHW = $clog2(`FU_XLEN);
	// cycles spent by all tests together, the watchdog allows twice this
	localparam int RUN_CYCLES = 6 + 16 + 12 + 3 * (M + 1) + (M + 4) + (2 * M + 2)
		+ (2 * M + 12) + 2;

	logic                  clk;
	logic                  arst_n_i;
	logic                  iss_vld_i;
	fu_sel_e               sel_i;
	alu_func_e             func_i;
	br_cond_e              cond_i;
	logic [`FU_XLEN-1:0]   opa_i;
	logic [`FU_XLEN-1:0]   opb_i;
	logic [`FU_XLEN-1:0]   npc_i;
	logic [`FU_XLEN-1:0]   disp_i;
	fu_tag_t               tag_i;
	logic                  recovery_i;
	logic                  pred_correct_i;
	logic [`BR_MASK_W-1:0] tag_fix_i;
	logic                  preg_wr_en_o;
	logic [`PRF_IDX_W-1:0] preg_wr_idx_o;
	logic [`FU_XLEN-1:0]   preg_wr_value_o;
	logic                  cdb_vld_o;
	logic                  rob_done_o;
	logic [`ROB_IDX_W-1:0] rob_idx_o;
	logic                  br_done_o;
	logic                  br_taken_o;
	logic [`FU_XLEN-1:0]   br_target_o;
	logic                  mult_rdy_o;

	int          errors;
	int          tests_run;
	int          tests_failed;
	int          test_base;
	logic [31:0] lfsr_state;

	fu_main fu_main_inst (.*);

	always #(CLK_PERIOD / 2) clk = ~clk;

	// fibonacci lfsr, taps 32 22 2 1
	function automatic logic lfsr_bit();
		lfsr_state = {lfsr_state[30:0],
			lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0]};
		return lfsr_state[0];
	endfunction

	function automatic logic [`FU_XLEN-1:0] rand_word();
		logic [`FU_XLEN-1:0] v;
		v = '0;
		for (int i = 0; i < `FU_XLEN; i++) begin
			v = {v[`FU_XLEN-2:0], lfsr_bit()};
		end
		return v;
	endfunction

	function automatic fu_tag_t tag_of(input int dest, input int rob,
		input logic [`BR_MASK_W-1:0] mask);
		fu_tag_t t;
		t.dest    = `PRF_IDX_W'(dest);
		t.rob_idx = `ROB_IDX_W'(rob);
		t.br_mask = mask;
		return t;
	endfunction

	// expected alu value from the operation definitions
	function automatic logic [`FU_XLEN-1:0] alu_ref(input alu_func_e f,
		input logic [`FU_XLEN-1:0] a, input logic [`FU_XLEN-1:0] b);
		case (f)
			alu_add: return a + b;
			alu_sub: return a - b;
			alu_and: return a & b;
			alu_or:  return a | b;
			alu_xor: return a ^ b;
			alu_sll: return a << b[SHW-1:0];
			alu_srl: return a >> b[SHW-1:0];
			default: return `FU_XLEN'($signed(a) < $signed(b));
		endcase
	endfunction

	// operand a tested against zero
	function automatic logic cond_holds(input br_cond_e c, input logic [`FU_XLEN-1:0] a);
		case (c)
			br_eq:   return a == '0;
			br_ne:   return a != '0;
			br_lt:   return a[`FU_XLEN-1];
			br_ge:   return !a[`FU_XLEN-1];
			default: return 1'b1;
		endcase
	endfunction

	task automatic mismatch(input string name, input logic [63:0] got, input logic [63:0] want);
		$display("FAIL %s got %h expected %h", name, got, want);
		errors++;
	endtask

	task automatic fault(input string msg);
		$display("error: %s", msg);
		errors++;
	endtask

	task automatic finish_test(input string name);
		tests_run++;
		if (errors == test_base) begin
			$display("%s: ok", name);
		end else begin
			tests_failed++;
			$display("%s: %0d errors", name, errors - test_base);
		end
		test_base = errors;
	endtask

	// next falling edge with all strobes idle
	task automatic tick();
		@(negedge clk);
		iss_vld_i      = 1'b0;
		recovery_i     = 1'b0;
		pred_correct_i = 1'b0;
		tag_fix_i      = '0;
	endtask

	task automatic settle();
		#(CLK_PERIOD / 4);
	endtask

	task automatic issue_op(input fu_sel_e sel, input alu_func_e func, input br_cond_e cond,
		input logic [`FU_XLEN-1:0] a, input logic [`FU_XLEN-1:0] b,
		input logic [`FU_XLEN-1:0] npc, input logic [`FU_XLEN-1:0] disp, input fu_tag_t t);
		iss_vld_i = 1'b1;
		sel_i     = sel;
		func_i    = func;
		cond_i    = cond;
		opa_i     = a;
		opb_i     = b;
		npc_i     = npc;
		disp_i    = disp;
		tag_i     = t;
	endtask

	task automatic wait_cdb(input int max_cycles, output int cycles, output logic seen);
		cycles = 0;
		seen   = 1'b0;
		while (!seen && cycles < max_cycles) begin
			tick();
			settle();
			cycles++;
			seen = cdb_vld_o;
		end
	endtask

	task automatic check_cdb(input fu_tag_t t, input logic [`FU_XLEN-1:0] value);
		if (preg_wr_en_o !== 1'b1)
			mismatch("preg_wr_en_o", 64'(preg_wr_en_o), 64'h1);
		if (preg_wr_idx_o !== t.dest)
			mismatch("preg_wr_idx_o", 64'(preg_wr_idx_o), 64'(t.dest));
		if (preg_wr_value_o !== value)
			mismatch("preg_wr_value_o", preg_wr_value_o, value);
		if (rob_done_o !== 1'b1)
			mismatch("rob_done_o", 64'(rob_done_o), 64'h1);
		if (rob_idx_o !== t.rob_idx)
			mismatch("rob_idx_o", 64'(rob_idx_o), 64'(t.rob_idx));
	endtask

	task automatic test_reset_state();
		settle();
		if (cdb_vld_o !== 1'b0)
			mismatch("cdb_vld_o", 64'(cdb_vld_o), 64'h0);
		if (preg_wr_en_o !== 1'b0)
			mismatch("preg_wr_en_o", 64'(preg_wr_en_o), 64'h0);
		if (rob_done_o !== 1'b0)
			mismatch("rob_done_o", 64'(rob_done_o), 64'h0);
		if (br_done_o !== 1'b0)
			mismatch("br_done_o", 64'(br_done_o), 64'h0);
		if (mult_rdy_o !== 1'b1)
			mismatch("mult_rdy_o", 64'(mult_rdy_o), 64'h1);
		finish_test("reset state");
	endtask

	task automatic test_alu();
		logic [`FU_XLEN-1:0] a;
		logic [`FU_XLEN-1:0] b;
		fu_tag_t             t;
		for (int f = 0; f < 8; f++) begin
			a = rand_word();
			b = rand_word();
			t = tag_of(f + 1, f, '0);
			tick();
			issue_op(sel_alu, alu_func_e'(f), br_eq, a, b, '0, '0, t);
			tick();
			settle();
			check_cdb(t, alu_ref(alu_func_e'(f), a, b));
		end
		finish_test("alu functions");
	endtask

	task automatic run_branch(input fu_sel_e sel, input br_cond_e cond,
		input logic [`FU_XLEN-1:0] a);
		logic [`FU_XLEN-1:0] npc;
		logic [`FU_XLEN-1:0] disp;
		fu_tag_t             t;
		logic                want;
		npc  = rand_word();
		disp = rand_word();
		t    = tag_of(2, 9, '0);
		want = cond_holds((sel == sel_uncond_branch) ? br_always : cond, a);
		tick();
		issue_op(sel, alu_add, cond, a, '0, npc, disp, t);
		tick();
		settle();
		if (br_done_o !== 1'b1)
			mismatch("br_done_o", 64'(br_done_o), 64'h1);
		if (br_taken_o !== want)
			mismatch("br_taken_o", 64'(br_taken_o), 64'(want));
		if (br_target_o !== npc + disp)
			mismatch("br_target_o", br_target_o, npc + disp);
		if (rob_done_o !== 1'b1)
			mismatch("rob_done_o", 64'(rob_done_o), 64'h1);
		if (rob_idx_o !== t.rob_idx)
			mismatch("rob_idx_o", 64'(rob_idx_o), 64'(t.rob_idx));
		if (cdb_vld_o !== 1'b0)
			mismatch("cdb_vld_o", 64'(cdb_vld_o), 64'h0);
	endtask

	task automatic test_branch();
		logic [`FU_XLEN-1:0] sign;
		sign = {1'b1, {(`FU_XLEN-1){1'b0}}};
		run_branch(sel_cond_branch, br_eq, '0);
		run_branch(sel_cond_branch, br_eq, rand_word() | 1);
		run_branch(sel_cond_branch, br_ne, '0);
		run_branch(sel_cond_branch, br_lt, rand_word() | sign);
		run_branch(sel_cond_branch, br_ge, rand_word() | sign);
		// unconditional ignores the condition code
		run_branch(sel_uncond_branch, br_eq, rand_word() | 1);
		finish_test("branch conditions");
	endtask

	task automatic test_mult();
		logic [`FU_XLEN-1:0] a;
		logic [`FU_XLEN-1:0] b;
		fu_tag_t             t;
		int                  cycles;
		logic                seen;
		for (int k = 0; k < 3; k++) begin
			a = rand_word();
			b = rand_word();
			t = tag_of(12 + k, 4 + k, '0);
			tick();
			issue_op(sel_mult, alu_add, br_eq, a, b, '0, '0, t);
			wait_cdb(M + 2, cycles, seen);
			if (!seen) begin
				fault("multiply result never reached the CDB");
			end else begin
				if (cycles != M)
					fault($sformatf("multiply took %0d cycles instead of %0d", cycles, M));
				check_cdb(t, a * b);
			end
		end
		finish_test("multiply");
	endtask

	task automatic test_collision();
		logic [`FU_XLEN-1:0] a;
		logic [`FU_XLEN-1:0] b;
		logic [`FU_XLEN-1:0] c;
		logic [`FU_XLEN-1:0] d;
		fu_tag_t             tm;
		fu_tag_t             ta;
		int                  cycles;
		logic                seen;
		a  = rand_word();
		b  = rand_word();
		c  = rand_word();
		d  = rand_word();
		tm = tag_of(20, 10, '0);
		ta = tag_of(21, 11, '0);
		tick();
		issue_op(sel_mult, alu_add, br_eq, a, b, '0, '0, tm);
		repeat (M - 1) tick();
		// alu finishes in the same cycle as the multiply
		issue_op(sel_alu, alu_xor, br_eq, c, d, '0, '0, ta);
		tick();
		settle();
		check_cdb(ta, c ^ d);
		if (mult_rdy_o !== 1'b1)
			mismatch("mult_rdy_o", 64'(mult_rdy_o), 64'h1);
		wait_cdb(M, cycles, seen);
		if (!seen)
			fault("held multiply never reached the CDB");
		else
			check_cdb(tm, a * b);
		finish_test("multiply after alu collision");
	endtask

	task automatic test_mult_stall();
		logic [`FU_XLEN-1:0] a [M];
		logic [`FU_XLEN-1:0] b [M];
		int                  cycles;
		logic                seen;
		for (int k = 0; k < M; k++) begin
			a[k] = rand_word();
			b[k] = rand_word();
			tick();
			issue_op(sel_mult, alu_add, br_eq, a[k], b[k], '0, '0, tag_of(24 + k, 16 + k, 4'b0001));
		end
		// full pipe frozen by a recovery that misses every mask
		tick();
		recovery_i = 1'b1;
		tag_fix_i  = 4'b1000;
		settle();
		if (mult_rdy_o !== 1'b0)
			mismatch("mult_rdy_o", 64'(mult_rdy_o), 64'h0);
		if (cdb_vld_o !== 1'b0)
			mismatch("cdb_vld_o", 64'(cdb_vld_o), 64'h0);
		for (int k = 0; k < M; k++) begin
			wait_cdb(M + 2, cycles, seen);
			if (!seen)
				fault($sformatf("multiply %0d lost after the stall", k));
			else
				check_cdb(tag_of(24 + k, 16 + k, 4'b0001), a[k] * b[k]);
		end
		finish_test("multiply stall");
	endtask

	task automatic test_recovery();
		logic [`FU_XLEN-1:0] a;
		logic [`FU_XLEN-1:0] b;
		fu_tag_t             t;
		int                  cycles;
		logic                seen;
		a = rand_word();
		b = rand_word();
		t = tag_of(5, 1, 4'b0010);
		tick();
		issue_op(sel_alu, alu_add, br_eq, a, b, '0, '0, t);
		recovery_i = 1'b1;
		tag_fix_i  = 4'b0010;
		tick();
		settle();
		if (cdb_vld_o !== 1'b0)
			mismatch("cdb_vld_o", 64'(cdb_vld_o), 64'h0);
		if (rob_done_o !== 1'b0)
			mismatch("rob_done_o", 64'(rob_done_o), 64'h0);
		t = tag_of(6, 2, 4'b0010);
		tick();
		issue_op(sel_alu, alu_add, br_eq, a, b, '0, '0, t);
		recovery_i = 1'b1;
		tag_fix_i  = 4'b0100;
		tick();
		settle();
		check_cdb(t, a + b);
		// multiply killed between stages
		t = tag_of(7, 3, 4'b0100);
		tick();
		issue_op(sel_mult, alu_add, br_eq, a, b, '0, '0, t);
		tick();
		recovery_i = 1'b1;
		tag_fix_i  = 4'b0100;
		wait_cdb(M + 2, cycles, seen);
		if (seen)
			fault("squashed multiply still wrote the CDB");
		t = tag_of(8, 4, 4'b0010);
		tick();
		issue_op(sel_mult, alu_add, br_eq, a, b, '0, '0, t);
		tick();
		pred_correct_i = 1'b1;
		tag_fix_i      = 4'b0010;
		tick();
		recovery_i = 1'b1;
		tag_fix_i  = 4'b0010;
		wait_cdb(M + 2, cycles, seen);
		if (!seen)
			fault("multiply with a cleared mask was squashed");
		else
			check_cdb(t, a * b);
		finish_test("recovery");
	endtask

	task automatic test_zero_reg();
		logic [`FU_XLEN-1:0] a;
		fu_tag_t             t;
		a = rand_word();
		t = tag_of(`ZERO_REG, 13, '0);
		tick();
		issue_op(sel_alu, alu_or, br_eq, a, a, '0, '0, t);
		tick();
		settle();
		if (preg_wr_en_o !== 1'b0)
			mismatch("preg_wr_en_o", 64'(preg_wr_en_o), 64'h0);
		if (cdb_vld_o !== 1'b0)
			mismatch("cdb_vld_o", 64'(cdb_vld_o), 64'h0);
		if (rob_done_o !== 1'b1)
			mismatch("rob_done_o", 64'(rob_done_o), 64'h1);
		if (rob_idx_o !== t.rob_idx)
			mismatch("rob_idx_o", 64'(rob_idx_o), 64'(t.rob_idx));
		finish_test("zero register");
	endtask

	initial begin
		#(2 * RUN_CYCLES * CLK_PERIOD);
		$display("watchdog expired before the tests finished");
		$display("Some tests failed");
		$finish;
	end

	initial begin
		clk            = 1'b0;
		arst_n_i       = 1'b0;
		iss_vld_i      = 1'b0;
		sel_i          = sel_none;
		func_i         = alu_add;
		cond_i         = br_eq;
		opa_i          = '0;
		opb_i          = '0;
		npc_i          = '0;
		disp_i         = '0;
		tag_i          = '0;
		recovery_i     = 1'b0;
		pred_correct_i = 1'b0;
		tag_fix_i      = '0;
		errors         = 0;
		tests_run      = 0;
		tests_failed   = 0;
		test_base      = 0;
		lfsr_state     = 32'hf3e4184d;
		repeat (5) @(negedge clk);
		arst_n_i = 1'b1;
		test_reset_state();
		test_alu();
		test_branch();
		test_mult();
		test_collision();
		test_mult_stall();
		test_recovery();
		test_zero_reg();
		$display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, errors);
		if (errors == 0)
			$display("All tests passed");
		else
			$display("Some tests failed");
		$finish;
	end

endmodule

//--- vlog.f
+incdir+include
hdl/fu_pkg.sv
hdl/fu_if.sv
hdl/fu_issue_decode.sv
hdl/fu_alu.sv
hdl/fu_br.sv
hdl/fu_mult_stage.sv
hdl/fu_cdb_arb.sv
hdl/fu_main.sv
verif/fu_main_tb.sv
